// File: Bender.yml
package:
  name: core_slice

export_include_dirs:
  - source

sources:
  - files:
      - source/isa_pkg.sv
      - source/pipe_pkg.sv
      - source/id_ex_if.sv
      - source/idu_decode.sv
      - source/idu_id_pipe.sv
      - source/gpr_regfile.sv
      - source/exu_alu.sv
      - source/pipe_ctrl.sv
      - source/core_top.sv
  - target: test
    files:
      - tests/core_asserts.sv
      - tests/core_tb.sv

// File: source/core_defines.svh
// global widths, control bus bit positions and trap vector, included by packages and RTL
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath widths
`define INST_ADDR_WIDTH 32          // program counter
`define XLEN            32          // register and ALU data
`define REG_ADDR_WIDTH  5           // x0..x31

// stall/flush bus
`define CU_BUS_WIDTH    2
`define CU_FLUSH        0           // drop the instruction being loaded
`define CU_STALL        1           // hold the pipe register

// illegal instructions redirect here
`define TRAP_VEC        32'h0000_0100

`endif

// File: source/core_top.sv
// two-stage RV32I slice top, instruction in from an external fetch unit, writeback out
`include "core_defines.svh"

module core_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        inst_valid_i,
    input  logic [`INST_ADDR_WIDTH-1:0] inst_addr_i,
    input  isa_pkg::inst_u              inst_i,
    input  logic                        hold_i,
    output logic                        wb_we_o,
    output logic [`REG_ADDR_WIDTH-1:0]  wb_waddr_o,
    output logic [`XLEN-1:0]            wb_wdata_o,
    output logic                        redirect_o,
    output logic [`INST_ADDR_WIDTH-1:0] redirect_addr_o,
    output logic [`INST_ADDR_WIDTH-1:0] trap_pc_o
);
    import pipe_pkg::*;

    cu_bus_t                     stall_flag;
    logic                        ex_commit;
    logic [`REG_ADDR_WIDTH-1:0]  raddr1;
    logic [`REG_ADDR_WIDTH-1:0]  raddr2;
    logic [`XLEN-1:0]            rdata1;
    logic [`XLEN-1:0]            rdata2;
    logic                        branch_taken;
    logic [`INST_ADDR_WIDTH-1:0] branch_target;
    logic                        trap;
    logic [`INST_ADDR_WIDTH-1:0] trap_pc;

    id_ex_if dec_bus ();    // decode to pipe register
    id_ex_if ex_bus ();     // pipe register to execute

    idu_decode u_decode (
        .inst_addr_i  (inst_addr_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .dec          (dec_bus.src)
    );

    idu_id_pipe u_id_pipe (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_flag_i (stall_flag),
        .dec          (dec_bus.dst),
        .ex           (ex_bus.src)
    );

    gpr_regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (wb_we_o),
        .waddr_i  (wb_waddr_o),
        .wdata_i  (wb_wdata_o)
    );

    exu_alu u_exu (
        .ex              (ex_bus.dst),
        .ex_commit_i     (ex_commit),
        .rdata1_i        (rdata1),
        .rdata2_i        (rdata2),
        .raddr1_o        (raddr1),
        .raddr2_o        (raddr2),
        .wb_we_o         (wb_we_o),
        .wb_waddr_o      (wb_waddr_o),
        .wb_wdata_o      (wb_wdata_o),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .trap_o          (trap),
        .trap_pc_o       (trap_pc)
    );

    pipe_ctrl u_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .hold_i          (hold_i),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .trap_i          (trap),
        .trap_pc_i       (trap_pc),
        .stall_flag_o    (stall_flag),
        .ex_commit_o     (ex_commit),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o),
        .trap_pc_o       (trap_pc_o)
    );

endmodule

// File: source/exu_alu.sv
// execute stage with operand read, ALU, branch resolution and writeback of one instruction
`include "core_defines.svh"

module exu_alu (
    id_ex_if.dst                        ex,
    input  logic                        ex_commit_i,
    input  logic [`XLEN-1:0]            rdata1_i,
    input  logic [`XLEN-1:0]            rdata2_i,
    output logic [`REG_ADDR_WIDTH-1:0]  raddr1_o,
    output logic [`REG_ADDR_WIDTH-1:0]  raddr2_o,
    output logic                        wb_we_o,
    output logic [`REG_ADDR_WIDTH-1:0]  wb_waddr_o,
    output logic [`XLEN-1:0]            wb_wdata_o,
    output logic                        branch_taken_o,
    output logic [`INST_ADDR_WIDTH-1:0] branch_target_o,
    output logic                        trap_o,
    output logic [`INST_ADDR_WIDTH-1:0] trap_pc_o
);
    import pipe_pkg::*;

    logic             commit;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] result;
    logic             src_eq;

    assign raddr1_o = ex.rs1;
    assign raddr2_o = ex.rs2;

    assign op_a    = ex.rs1_re ? rdata1_i : '0;
    assign rs2_val = ex.rs2_re ? rdata2_i : '0;
    assign op_b    = ex.dec_info.use_imm ? ex.imm : rs2_val;

    always_comb begin
        case (ex.dec_info.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    assign commit = ex_commit_i & ex.inst_valid;  // held or bubble does nothing
    assign src_eq = (op_a == rs2_val);

    assign wb_we_o    = commit & ex.reg_we & ~ex.illegal;
    assign wb_waddr_o = ex.rd;
    assign wb_wdata_o = result;

    assign branch_taken_o  = commit & ex.dec_info.is_branch & ~ex.illegal &
                             (src_eq ^ ex.dec_info.branch_ne);
    assign branch_target_o = ex.inst_addr + ex.imm;

    assign trap_o    = commit & ex.illegal;
    assign trap_pc_o = ex.inst_addr;  // live address that pipe_ctrl latches

endmodule

// File: source/gpr_regfile.sv
// general purpose registers x0..x31, read combinationally in execute, written at cycle end
`include "core_defines.svh"

module gpr_regfile (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2_i,
    output logic [`XLEN-1:0]           rdata1_o,
    output logic [`XLEN-1:0]           rdata2_o,
    input  logic                       we_i,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [`XLEN-1:0]           wdata_i
);

    logic [`XLEN-1:0] regs [2**`REG_ADDR_WIDTH];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;   // decoder never asserts we for x0
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: source/id_ex_if.sv
// one decoded instruction moving from decode towards execute, no handshake
`include "core_defines.svh"

interface id_ex_if;
    import pipe_pkg::*;

    logic                        inst_valid;
    logic [`INST_ADDR_WIDTH-1:0] inst_addr;
    logic                        illegal;
    logic                        reg_we;    // never set for rd == x0
    logic [`REG_ADDR_WIDTH-1:0]  rd;
    logic [`REG_ADDR_WIDTH-1:0]  rs1;
    logic [`REG_ADDR_WIDTH-1:0]  rs2;
    logic                        rs1_re;
    logic                        rs2_re;
    logic [`XLEN-1:0]            imm;       // already sign extended
    dec_info_t                   dec_info;

    modport src (output inst_valid, inst_addr, illegal, reg_we, rd,
                 output rs1, rs2, rs1_re, rs2_re, imm, dec_info);
    modport dst (input inst_valid, inst_addr, illegal, reg_we, rd,
                 input rs1, rs2, rs1_re, rs2_re, imm, dec_info);

endinterface

// File: source/idu_decode.sv
// combinational RV32I subset decoder feeding the decode-to-execute register
`include "core_defines.svh"

module idu_decode (
    input  logic [`INST_ADDR_WIDTH-1:0] inst_addr_i,
    input  isa_pkg::inst_u              inst_i,
    input  logic                        inst_valid_i,
    id_ex_if.src                        dec
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic legal;
    logic writes_rd;

    always_comb begin
        legal         = 1'b0;
        writes_rd     = 1'b0;
        dec.rd        = '0;
        dec.rs1       = '0;
        dec.rs2       = '0;
        dec.rs1_re    = 1'b0;
        dec.rs2_re    = 1'b0;
        dec.imm       = '0;
        dec.dec_info  = '0;

        case (inst_i.r.opcode)       // opcode sits at the same bits in every view
            OPC_OP: begin
                dec.rd     = inst_i.r.rd;
                dec.rs1    = inst_i.r.rs1;
                dec.rs2    = inst_i.r.rs2;
                dec.rs1_re = 1'b1;
                dec.rs2_re = 1'b1;
                writes_rd  = 1'b1;
                legal      = 1'b1;
                case ({inst_i.r.funct7, inst_i.r.funct3})
                    {7'h00, 3'h0}: dec.dec_info.alu_op = ALU_ADD;
                    {7'h20, 3'h0}: dec.dec_info.alu_op = ALU_SUB;
                    {7'h00, 3'h7}: dec.dec_info.alu_op = ALU_AND;
                    {7'h00, 3'h6}: dec.dec_info.alu_op = ALU_OR;
                    {7'h00, 3'h4}: dec.dec_info.alu_op = ALU_XOR;
                    default:       legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                dec.rd               = inst_i.i.rd;
                dec.rs1              = inst_i.i.rs1;
                dec.rs1_re           = 1'b1;
                dec.imm              = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
                dec.dec_info.use_imm = 1'b1;
                writes_rd            = 1'b1;
                legal                = (inst_i.i.funct3 == 3'h0); // ADDI only
            end
            OPC_LUI: begin
                dec.rd               = inst_i.u.rd;
                dec.imm              = {inst_i.u.imm31_12, 12'h000};
                dec.dec_info.alu_op  = ALU_PASS_B;
                dec.dec_info.use_imm = 1'b1;
                writes_rd            = 1'b1;
                legal                = 1'b1;
            end
            OPC_BRANCH: begin
                dec.rs1    = inst_i.b.rs1;
                dec.rs2    = inst_i.b.rs2;
                dec.rs1_re = 1'b1;
                dec.rs2_re = 1'b1;
                dec.imm    = {{19{inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                              inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
                dec.dec_info.is_branch = 1'b1;
                dec.dec_info.branch_ne = inst_i.b.funct3[0];
                legal      = (inst_i.b.funct3[2:1] == 2'b00); // BEQ, BNE
            end
            default: legal = 1'b0;
        endcase
    end

    assign dec.inst_valid = inst_valid_i;
    assign dec.inst_addr  = inst_addr_i;
    assign dec.illegal    = ~legal;
    assign dec.reg_we     = legal & writes_rd & (dec.rd != '0); // x0 writes dropped here

endmodule

// File: source/idu_id_pipe.sv
// decode-to-execute pipeline register, holds on stall and loads a bubble on flush
`include "core_defines.svh"

module idu_id_pipe (
    input  logic             clk,
    input  logic             rst_n_i,
    input  pipe_pkg::cu_bus_t stall_flag_i,
    id_ex_if.dst             dec,
    id_ex_if.src             ex
);

    logic flush_en;
    logic stall_en;

    assign flush_en = stall_flag_i[`CU_FLUSH];
    assign stall_en = stall_flag_i[`CU_STALL];

    // register addresses travel on, the register file is read in execute
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex.inst_valid <= 1'b0;
            ex.inst_addr  <= '0;
            ex.illegal    <= 1'b0;
            ex.reg_we     <= 1'b0;
            ex.rd         <= '0;
            ex.rs1        <= '0;
            ex.rs2        <= '0;
            ex.rs1_re     <= 1'b0;
            ex.rs2_re     <= 1'b0;
            ex.imm        <= '0;
            ex.dec_info   <= '0;
        end else if (!stall_en) begin
            ex.inst_valid <= flush_en ? 1'b0 : dec.inst_valid;  // wrong path dropped
            ex.inst_addr  <= flush_en ? '0 : dec.inst_addr;
            ex.illegal    <= flush_en ? 1'b0 : dec.illegal;
            ex.reg_we     <= flush_en ? 1'b0 : dec.reg_we;
            ex.rd         <= flush_en ? '0 : dec.rd;
            ex.rs1        <= flush_en ? '0 : dec.rs1;
            ex.rs2        <= flush_en ? '0 : dec.rs2;
            ex.rs1_re     <= flush_en ? 1'b0 : dec.rs1_re;
            ex.rs2_re     <= flush_en ? 1'b0 : dec.rs2_re;
            ex.imm        <= flush_en ? '0 : dec.imm;
            ex.dec_info   <= flush_en ? '0 : dec.dec_info;
        end
    end

endmodule

// File: source/isa_pkg.sv
// RV32I instruction formats and opcodes, used by the decoder to view one instruction word
`include "core_defines.svh"

package isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,        // register-register
        OPC_OP_IMM = 7'b0010011,        // register-immediate
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        opcode_e                    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]                imm;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        opcode_e                    opcode;
    } i_type_t;

    // branch offset is scattered across the word
    typedef struct packed {
        logic                       imm12;
        logic [5:0]                 imm10_5;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [3:0]                 imm4_1;
        logic                       imm11;
        opcode_e                    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0]                imm31_12;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        opcode_e                    opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        b_type_t b;
        u_type_t u;
    } inst_u;

endpackage

// File: source/pipe_ctrl.sv
// pipeline control with stall/flush bus, commit enable, redirect select and trap address latch
`include "core_defines.svh"

module pipe_ctrl (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        hold_i,
    input  logic                        branch_taken_i,
    input  logic [`INST_ADDR_WIDTH-1:0] branch_target_i,
    input  logic                        trap_i,
    input  logic [`INST_ADDR_WIDTH-1:0] trap_pc_i,
    output pipe_pkg::cu_bus_t           stall_flag_o,
    output logic                        ex_commit_o,
    output logic                        redirect_o,
    output logic [`INST_ADDR_WIDTH-1:0] redirect_addr_o,
    output logic [`INST_ADDR_WIDTH-1:0] trap_pc_o
);

    assign stall_flag_o[`CU_STALL] = hold_i;
    assign stall_flag_o[`CU_FLUSH] = (branch_taken_i | trap_i) & ~hold_i;
    assign ex_commit_o             = ~hold_i;

    // trap takes priority over the branch target
    assign redirect_o      = branch_taken_i | trap_i;
    assign redirect_addr_o = trap_i ? `TRAP_VEC : branch_target_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trap_pc_o <= '0;
        end else if (trap_i) begin
            trap_pc_o <= trap_pc_i;     // address of the illegal instruction
        end
    end

endmodule

// File: source/pipe_pkg.sv
// decoded-control and stall/flush types shared by the pipeline stages
`include "core_defines.svh"

package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5           // LUI result is the immediate
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;           // operand b from immediate
        logic    is_branch;
        logic    branch_ne;         // BNE when set, BEQ otherwise
    } dec_info_t;

    // indexed by CU_FLUSH and CU_STALL
    typedef logic [`CU_BUS_WIDTH-1:0] cu_bus_t;

endpackage

// File: src.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/id_ex_if.sv
source/idu_decode.sv
source/idu_id_pipe.sv
source/gpr_regfile.sv
source/exu_alu.sv
source/pipe_ctrl.sv
source/core_top.sv
tests/core_asserts.sv
tests/core_tb.sv

// File: tests/core_asserts.sv
// concurrent checks on the decode-to-execute register that are bound into idu_id_pipe
`include "core_defines.svh"

module core_asserts #(
    parameter int FIELD_W = `INST_ADDR_WIDTH + `XLEN + 3 * `REG_ADDR_WIDTH + 11
) (
    input logic                       clk_i,
    input logic                       rst_n_i,
    input logic                       stall_i,
    input logic                       flush_i,
    input logic                       valid_i,
    input logic                       reg_we_i,
    input logic [`REG_ADDR_WIDTH-1:0] rd_i,
    input logic [FIELD_W-1:0]         fields_i   // every registered field
);

    int fail_count = 0;

    stall_keeps_fields: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> $stable(fields_i))
        else begin
            $error("pipe register changed while stalled");
            fail_count = fail_count + 1;
        end

    flush_drops_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (flush_i && !stall_i) |=> !valid_i)
        else begin
            $error("valid still set after a flush");
            fail_count = fail_count + 1;
        end

    no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reg_we_i |-> (rd_i != '0))
        else begin
            $error("reg_we set with rd equal to x0");
            fail_count = fail_count + 1;
        end

endmodule

bind idu_id_pipe core_asserts u_asserts (
    .clk_i    (clk),
    .rst_n_i  (rst_n_i),
    .stall_i  (stall_flag_i[`CU_STALL]),
    .flush_i  (stall_flag_i[`CU_FLUSH]),
    .valid_i  (ex.inst_valid),
    .reg_we_i (ex.reg_we),
    .rd_i     (ex.rd),
    .fields_i ({ex.inst_valid, ex.inst_addr, ex.illegal, ex.reg_we, ex.rd, ex.rs1, ex.rs2,
                ex.rs1_re, ex.rs2_re, ex.imm, ex.dec_info})
);

// File: tests/core_tb.sv
// directed testbench that applies an instruction table to core_top and checks commits in order
`include "core_defines.svh"

module core_tb;
    import isa_pkg::*;

    localparam int EV_NONE  = 0;
    localparam int EV_WB    = 1;
    localparam int EV_REDIR = 2;
    localparam int EV_TRAP  = 3;
    localparam int MAX_ROWS = 32;

    logic                        clk;
    logic                        rst_n_i;
    logic                        inst_valid_i;
    logic [`INST_ADDR_WIDTH-1:0] inst_addr_i;
    logic [31:0]                 inst_i;
    logic                        hold_i;
    logic                        wb_we_o;
    logic [`REG_ADDR_WIDTH-1:0]  wb_waddr_o;
    logic [`XLEN-1:0]            wb_wdata_o;
    logic                        redirect_o;
    logic [`INST_ADDR_WIDTH-1:0] redirect_addr_o;
    logic [`INST_ADDR_WIDTH-1:0] trap_pc_o;

    string       row_name [MAX_ROWS];
    logic [31:0] row_inst [MAX_ROWS];
    logic [31:0] row_addr [MAX_ROWS];
    int          row_hold [MAX_ROWS];
    int          row_kind [MAX_ROWS];
    logic [4:0]  row_rd   [MAX_ROWS];
    logic [31:0] row_val  [MAX_ROWS];   // wb data or redirect target
    int          n_rows;
    int          exp_row [$];           // rows that must produce an event in order
    int          exp_head;
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;
    logic        trap_pending;
    int          trap_row;
    logic [31:0] x [32];                // reference register values
    logic [31:0] pc;

    core_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] addi_word(logic [11:0] imm, logic [4:0] rs1,
                                              logic [4:0] rd);
        return {imm, rs1, 3'h0, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] branch_word(logic bne, logic [4:0] rs1, logic [4:0] rs2,
                                                logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], OPC_BRANCH};
    endfunction

    task automatic add_row(string name, logic [31:0] inst, int hold, int kind,
                           logic [4:0] rd, logic [31:0] val);
        row_name[n_rows] = name;
        row_inst[n_rows] = inst;
        row_addr[n_rows] = pc;
        row_hold[n_rows] = hold;
        row_kind[n_rows] = kind;
        row_rd[n_rows]   = rd;
        row_val[n_rows]  = val;
        if (kind != EV_NONE) begin
            exp_row.push_back(n_rows);
        end
        n_rows = n_rows + 1;
        pc     = pc + 32'd4;
    endtask

    task automatic build_table();
        logic [31:0] target;
        foreach (x[k]) x[k] = '0;
        pc = 32'h0000_1000;
        x[1] = 32'h1234_5000;
        add_row("lui_x1", lui_word(20'h12345, 1), 0, EV_WB, 1, x[1]);
        x[1] = x[1] + 32'h678;
        add_row("addi_x1", addi_word(12'h678, 1, 1), 0, EV_WB, 1, x[1]);
        x[2] = x[0] - 32'd5;
        add_row("addi_neg", addi_word(12'hffb, 0, 2), 0, EV_WB, 2, x[2]);
        x[3] = x[1] + x[2];
        add_row("add_x3", r_word(7'h00, 2, 1, 3'h0, 3), 0, EV_WB, 3, x[3]);
        x[4] = x[3] - x[1];
        add_row("sub_x4", r_word(7'h20, 1, 3, 3'h0, 4), 0, EV_WB, 4, x[4]);
        x[5] = x[1] & x[2];
        add_row("and_x5", r_word(7'h00, 2, 1, 3'h7, 5), 0, EV_WB, 5, x[5]);
        x[6] = x[1] | x[4];
        add_row("or_x6", r_word(7'h00, 4, 1, 3'h6, 6), 0, EV_WB, 6, x[6]);
        x[7] = x[6] ^ x[3];
        add_row("xor_x7", r_word(7'h00, 3, 6, 3'h4, 7), 0, EV_WB, 7, x[7]);
        add_row("addi_x0", addi_word(12'h007, 1, 0), 0, EV_NONE, 0, 0);
        x[8] = x[0] + x[7];
        add_row("add_read_x0", r_word(7'h00, 7, 0, 3'h0, 8), 0, EV_WB, 8, x[8]);
        x[9] = x[8] + 32'd1;
        add_row("hold_addi", addi_word(12'h001, 8, 9), 2 + ($urandom % 4), EV_WB, 9, x[9]);
        target = pc + 32'd16;
        add_row("beq_taken", branch_word(1'b0, 8, 7, 13'd16), 0, EV_REDIR, 0, target);
        add_row("beq_shadow", addi_word(12'h001, 0, 10), 0, EV_NONE, 0, 0);
        pc = target;
        add_row("bne_not_taken", branch_word(1'b1, 8, 7, 13'd8), 0, EV_NONE, 0, 0);
        x[11] = 32'h55;
        add_row("after_bne", addi_word(12'h055, 0, 11), 0, EV_WB, 11, x[11]);
        target = pc - 32'd32;
        add_row("bne_taken", branch_word(1'b1, 11, 0, -13'sd32), 0, EV_REDIR, 0, target);
        add_row("bne_shadow", r_word(7'h00, 1, 1, 3'h0, 12), 0, EV_NONE, 0, 0);
        pc = target;
        add_row("illegal_slt", r_word(7'h00, 2, 1, 3'h2, 13), 0, EV_TRAP, 0, `TRAP_VEC);
        add_row("trap_shadow", addi_word(12'h003, 0, 14), 0, EV_NONE, 0, 0);
        pc = `TRAP_VEC;
        x[15] = x[3] + x[5];
        add_row("after_trap", r_word(7'h00, 5, 3, 3'h0, 15), 0, EV_WB, 15, x[15]);
    endtask

    // compare each observed commit with the next expected event
    always @(negedge clk) begin
        int r;
        if (rst_n_i) begin
            if (trap_pending) begin
                trap_pending = 1'b0;
                checks = checks + 1;
                if (trap_pc_o !== row_addr[trap_row]) begin
                    $display("Error %s: expected trap_pc %h, actual %h", row_name[trap_row],
                             row_addr[trap_row], trap_pc_o);
                    errors = errors + 1;
                end
            end
            if (wb_we_o || redirect_o) begin
                checks = checks + 1;
                if (exp_head >= exp_row.size()) begin
                    $display("unexpected commit event at %0t with no event left", $time);
                    errors = errors + 1;
                end else begin
                    r = exp_row[exp_head];
                    exp_head = exp_head + 1;
                    if (wb_we_o && redirect_o) begin
                        $display("%s: writeback and redirect in the same cycle", row_name[r]);
                        errors = errors + 1;
                    end else if (wb_we_o) begin
                        if (row_kind[r] != EV_WB) begin
                            $display("%s: got a writeback where a redirect was due", row_name[r]);
                            errors = errors + 1;
                        end else if (wb_waddr_o !== row_rd[r] || wb_wdata_o !== row_val[r]) begin
                            $display("Error %s: expected x%0d=%h, actual x%0d=%h", row_name[r],
                                     row_rd[r], row_val[r], wb_waddr_o, wb_wdata_o);
                            errors = errors + 1;
                        end
                    end else begin
                        if (row_kind[r] == EV_WB) begin
                            $display("%s: got a redirect where a writeback was due", row_name[r]);
                            errors = errors + 1;
                        end else if (redirect_addr_o !== row_val[r]) begin
                            $display("Error %s: expected %h, actual %h", row_name[r],
                                     row_val[r], redirect_addr_o);
                            errors = errors + 1;
                        end
                        if (row_kind[r] == EV_TRAP) begin
                            trap_pending = 1'b1;        // trap_pc_o checked next cycle
                            trap_row     = r;
                        end
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int total_hold;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_addr_i  = '0;
        inst_i       = '0;
        hold_i       = 1'b0;
        n_rows       = 0;
        exp_head     = 0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        cycle_limit  = 0;
        trap_pending = 1'b0;
        trap_row     = 0;
        void'($urandom(32'h9229));
        build_table();
        total_hold = 0;
        for (int i = 0; i < n_rows; i++) begin
            total_hold = total_hold + row_hold[i];
        end
        cycle_limit = 4 * n_rows + total_hold + 20;

        repeat (2) @(posedge clk);
        #1 rst_n_i = 1'b1;
        @(negedge clk);
        checks = checks + 1;
        if (wb_we_o !== 1'b0 || redirect_o !== 1'b0 || trap_pc_o !== '0) begin
            $display("Error reset: expected we=0 redirect=0 trap_pc=0, actual we=%b "
                     , wb_we_o, "redirect=%b trap_pc=%h", redirect_o, trap_pc_o);
            errors = errors + 1;
        end

        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            #1;
            inst_valid_i = 1'b1;
            inst_addr_i  = row_addr[i];
            inst_i       = row_inst[i];
            hold_i       = 1'b0;
            for (int h = 0; h < row_hold[i]; h++) begin
                @(posedge clk);
                #1 hold_i = 1'b1;               // fetch side keeps the same instruction
            end
        end
        @(posedge clk);
        #1;
        inst_valid_i = 1'b0;
        hold_i       = 1'b0;
        repeat (4) @(posedge clk);

        if (exp_head != exp_row.size()) begin
            $display("%0d expected commit events never arrived", exp_row.size() - exp_head);
            errors = errors + 1;
        end
        if (dut0.u_id_pipe.u_asserts.fail_count != 0) begin
            $display("%0d assertions on the pipe register failed",
                     dut0.u_id_pipe.u_asserts.fail_count);
            errors = errors + dut0.u_id_pipe.u_asserts.fail_count;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
